//--- rvCore.f
+incdir+.
rvCorePkg.sv
programCounter.sv
instrMemory.sv
controlUnit.sv
immExtend.sv
regFile.sv
alu.sv
dataMemory.sv
rvCore.sv
tbRvCore.sv

//--- runSim.sh
#!/bin/sh
# Build with Verilator, run, and fail if the log reports a failure
verilator --binary --timing -Wno-fatal --top-module tbRvCore -f rvCore.f -o simRvCore \
    && ./obj_dir/simRvCore > sim.log 2>&1 \
    || { echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0

//--- rvModel.svh
// Instruction-set model, random program builder and compare tasks for tbRvCore.
// Included in the testbench module. Programs use forward flow and base x0 accesses only.
`ifndef rvModelSvh
`define rvModelSvh

// Word 0 writes a0, then data clear, random body, register clear and self-jump
localparam int prologueLen = rvCorePkg::dmemBytes / 4 + 1;
localparam int bodyLen     = 60;
localparam int bodyEnd     = prologueLen + bodyLen;
localparam int progLen     = bodyEnd + 32;
localparam int finalAddr   = 4 * (progLen - 1);

logic [31:0]                progWords [rvCorePkg::imemWords];
logic [rvCorePkg::xlen-1:0] modelRegs [32];
logic [7:0]                 modelMem  [rvCorePkg::dmemBytes];
logic [rvCorePkg::xlen-1:0] modelPc;
int                         wordErrors = 0;
int                         pcErrors = 0;

function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rvCorePkg::opStore};
endfunction

function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rvCorePkg::opBranch};
endfunction

function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvCorePkg::opJal};
endfunction

// Biased toward the observed registers and x0
function automatic logic [4:0] pickReg();
    logic [2:0] sel;
    sel = 3'($urandom % 8);
    case (sel)
        3'd0:    return 5'd0;
        3'd1:    return 5'd10;
        3'd2:    return 5'd11;
        3'd3:    return 5'd17;
        3'd4:    return 5'd5;
        default: return 5'($urandom % 32);
    endcase
endfunction

function automatic logic [11:0] alignedOffset(input logic [2:0] f3);
    logic [11:0] off;
    off = 12'($urandom % rvCorePkg::dmemBytes);
    if (f3[0])
        off[0] = 1'b0;
    if (f3[1])
        off[1:0] = 2'b00;
    return off;
endfunction

function automatic logic [31:0] randomInstr(input int idx);
    logic [31:0] ins;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic        alt;
    int          span;
    int          m;
    rd  = pickReg();
    rs1 = pickReg();
    rs2 = pickReg();
    f3  = 3'($urandom % 8);
    imm = 12'($urandom);
    alt = 1'($urandom) & (f3 == 3'b000 || f3 == 3'b101);
    m   = int'($urandom % 6);
    // Forward distance in words that lands no later than the first register clear
    span = 1 + int'($urandom % 4);
    if (idx + span > bodyEnd)
        span = bodyEnd - idx;
    case ($urandom % 16)
        0, 1, 2, 3: ins = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, rvCorePkg::opOp};
        4, 5, 6: begin
            // Shift immediates only carry the arithmetic flag above shamt
            if (f3 == 3'b001 || f3 == 3'b101)
                imm[11:5] = {1'b0, alt, 5'b0};
            ins = encI(imm, rs1, f3, rd, rvCorePkg::opOpImm);
        end
        7: ins = {20'($urandom), rd, rvCorePkg::opLui};
        8, 9: begin
            f3  = ((m % 5) < 3) ? 3'(m % 5) : 3'((m % 5) + 1);
            ins = encI(alignedOffset(f3), 5'd0, f3, rd, rvCorePkg::opLoad);
        end
        10, 11: begin
            f3  = 3'(m % 3);
            ins = encS(alignedOffset(f3), rs2, 5'd0, f3);
        end
        12, 13: begin
            f3  = (m < 2) ? 3'(m) : 3'(m + 2);
            ins = encB(13'(4 * span), rs2, rs1, f3);
        end
        14: ins = encJ(21'(4 * span), rd);
        // Odd target checks that bit 0 is dropped
        15: ins = encI(12'(4 * (idx + span) + int'($urandom % 2)), 5'd0, 3'b000, rd,
                       rvCorePkg::opJalr);
        default: ins = encI(12'd0, 5'd0, 3'b000, 5'd0, rvCorePkg::opOpImm);
    endcase
    return ins;
endfunction

task automatic buildProgram();
    int i;
    // Nonzero lui into a0 sits at pc 0 for the whole reset hold
    progWords[0] = {20'($urandom) | 20'd1, 5'd10, rvCorePkg::opLui};
    for (i = 1; i < prologueLen; i++)
        progWords[i] = encS(12'(4 * (i - 1)), 5'd0, 5'd0, 3'b010);
    for (i = prologueLen; i < bodyEnd; i++)
        progWords[i] = randomInstr(i);
    for (i = 1; i < 32; i++)
        progWords[bodyEnd + i - 1] = encI(12'd0, 5'd0, 3'b000, 5'(i), rvCorePkg::opOpImm);
    progWords[progLen - 1] = encJ(21'd0, 5'd0);
endtask

task automatic clearModel();
    int i;
    for (i = 0; i < 32; i++)
        modelRegs[i] = '0;
    for (i = 0; i < rvCorePkg::dmemBytes; i++)
        modelMem[i] = '0;
    modelPc = '0;
endtask

function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'b000: return alt ? a - b : a + b;
        3'b001: return a << b[4:0];
        3'b010: return {31'b0, $signed(a) < $signed(b)};
        3'b011: return {31'b0, a < b};
        3'b100: return a ^ b;
        3'b101: begin
            if (alt)
                return $signed(a) >>> b[4:0];
            return a >> b[4:0];
        end
        3'b110: return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic [31:0] loadModel(input logic [2:0] f3, input logic [7:0] addr);
    logic [31:0] w;
    w = {modelMem[addr + 8'd3], modelMem[addr + 8'd2], modelMem[addr + 8'd1], modelMem[addr]};
    case (f3)
        3'b000:  return {{24{w[7]}}, w[7:0]};
        3'b001:  return {{16{w[15]}}, w[15:0]};
        3'b100:  return {24'b0, w[7:0]};
        3'b101:  return {16'b0, w[15:0]};
        default: return w;
    endcase
endfunction

// Retire the instruction at modelPc
task automatic modelStep();
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] iImm;
    logic [31:0] res;
    logic [31:0] nextPc;
    logic [7:0]  addr;
    logic [2:0]  f3;
    logic        wr;
    logic        taken;
    ins    = progWords[modelPc[9:2]];
    f3     = ins[14:12];
    a      = modelRegs[ins[19:15]];
    b      = modelRegs[ins[24:20]];
    iImm   = {{20{ins[31]}}, ins[31:20]};
    nextPc = modelPc + 32'd4;
    res    = '0;
    wr     = 1'b0;
    taken  = 1'b0;
    case (ins[6:0])
        rvCorePkg::opOp, rvCorePkg::opOpImm: begin
            if (ins[6:0] == rvCorePkg::opOpImm)
                b = iImm;
            res = aluModel(f3, ins[30] && (ins[6:0] == rvCorePkg::opOp || f3 == 3'b101), a, b);
            wr  = 1'b1;
        end
        rvCorePkg::opLoad: begin
            addr = 8'(a + iImm);
            res  = loadModel(f3, addr);
            wr   = 1'b1;
        end
        rvCorePkg::opStore: begin
            addr = 8'(a + {{20{ins[31]}}, ins[31:25], ins[11:7]});
            modelMem[addr] = b[7:0];
            if (f3 != 3'b000)
                modelMem[addr + 8'd1] = b[15:8];
            if (f3 == 3'b010) begin
                modelMem[addr + 8'd2] = b[23:16];
                modelMem[addr + 8'd3] = b[31:24];
            end
        end
        rvCorePkg::opBranch: begin
            case (f3)
                3'b000:  taken = (a == b);
                3'b001:  taken = (a != b);
                3'b100:  taken = ($signed(a) < $signed(b));
                3'b101:  taken = ($signed(a) >= $signed(b));
                3'b110:  taken = (a < b);
                default: taken = (a >= b);
            endcase
            if (taken)
                nextPc = modelPc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        end
        rvCorePkg::opJal: begin
            res    = modelPc + 32'd4;
            wr     = 1'b1;
            nextPc = modelPc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        rvCorePkg::opJalr: begin
            res    = modelPc + 32'd4;
            wr     = 1'b1;
            nextPc = (a + iImm) & ~32'd1;
        end
        rvCorePkg::opLui: begin
            res = {ins[31:12], 12'b0};
            wr  = 1'b1;
        end
        default: begin
        end
    endcase
    if (wr && ins[11:7] != 5'd0)
        modelRegs[ins[11:7]] = res;
    modelPc = nextPc;
endtask

task automatic checkWord(input string testName, input string regName,
                         input logic [rvCorePkg::xlen-1:0] expected,
                         input logic [rvCorePkg::xlen-1:0] actual);
    if (actual !== expected) begin
        wordErrors++;
        $display("MISMATCH %s %s: expected %h, actual %h", testName, regName, expected, actual);
    end
endtask

task automatic checkPc(input string testName, input logic [rvCorePkg::xlen-1:0] expected,
                       input logic [rvCorePkg::xlen-1:0] actual);
    if (actual !== expected) begin
        pcErrors++;
        $display("MISMATCH %s pc: expected %h, actual %h", testName, expected, actual);
    end
endtask

`endif

//--- tbRvCore.sv
// Random-program testbench for rvCore, compared against an instruction-set model.
// Registers survive reset, so the model keeps its state from one program to the next.
`timescale 1ns/10ps
module tbRvCore;

    localparam int numPrograms = 8;

    logic                       clk;
    logic                       reset;
    logic                       progWe;
    logic [7:0]                 progAddr;
    logic [31:0]                progData;
    logic [rvCorePkg::xlen-1:0] pc;
    logic [rvCorePkg::xlen-1:0] a0;
    logic [rvCorePkg::xlen-1:0] a1;
    logic [rvCorePkg::xlen-1:0] a7;
    int                         cycles = 0;

    `include "rvModel.svh"

    // Load, reset hold, run to the self-jump, plus slack, for each program
    localparam int cycleLimit = numPrograms * (2 * progLen + 3 + 10);

    rvCore i_dut (
        .clk(clk), .reset(reset), .progWe(progWe), .progAddr(progAddr),
        .progData(progData), .pc(pc), .a0(a0), .a1(a1), .a7(a7)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("Run timed out after %0d cycles without finishing all programs", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic checkState(input string testName);
        checkPc(testName, modelPc, pc);
        checkWord(testName, "a0", modelRegs[10], a0);
        checkWord(testName, "a1", modelRegs[11], a1);
        checkWord(testName, "a7", modelRegs[17], a7);
    endtask

    // Core held in reset, so pc sits at 0 and no register changes
    task automatic loadProgram(input int progNum);
        int i;
        for (i = 0; i < progLen; i++) begin
            @(negedge clk);
            checkState($sformatf("prog%0d load%0d", progNum, i));
            reset    = 1'b1;
            progWe   = 1'b1;
            progAddr = 8'(i);
            progData = progWords[i];
            modelPc  = '0;
        end
        @(negedge clk);
        progWe = 1'b0;
        repeat (3) begin
            @(negedge clk);
            checkState($sformatf("prog%0d reset", progNum));
        end
        reset = 1'b0;
    endtask

    task automatic runProgram(input int progNum);
        int step;
        step = 0;
        while (modelPc != 32'(finalAddr)) begin
            modelStep();
            @(negedge clk);
            step++;
            checkState($sformatf("prog%0d step%0d", progNum, step));
        end
        // Self-jump keeps pc in place
        modelStep();
        @(negedge clk);
        checkState($sformatf("prog%0d selfjump", progNum));
    endtask

    initial begin
        int p;
        clk      = 1'b0;
        reset    = 1'b1;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        void'($urandom(32'h4ee3));
        clearModel();
        for (p = 0; p < numPrograms; p++) begin
            buildProgram();
            loadProgram(p);
            runProgram(p);
        end
        $display("pc errors: %0d, register errors: %0d", pcErrors, wordErrors);
        if (pcErrors == 0 && wordErrors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- rvCore.sv
// Single-cycle RV32I core, one instruction retires per rising clock edge.
// Program load through progWe is accepted only while reset is high.
`timescale 1ns/10ps
module rvCore (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         progWe,
    input  logic [7:0]                   progAddr,
    input  logic [31:0]                  progData,
    output logic [rvCorePkg::xlen-1:0]   pc,
    output logic [rvCorePkg::xlen-1:0]   a0,
    output logic [rvCorePkg::xlen-1:0]   a1,
    output logic [rvCorePkg::xlen-1:0]   a7
);

    logic [rvCorePkg::xlen-1:0] instr;
    logic [rvCorePkg::xlen-1:0] imm;
    logic [rvCorePkg::xlen-1:0] readData1;
    logic [rvCorePkg::xlen-1:0] readData2;
    logic [rvCorePkg::xlen-1:0] srcB;
    logic [rvCorePkg::xlen-1:0] aluResult;
    logic [rvCorePkg::xlen-1:0] readData;
    logic [rvCorePkg::xlen-1:0] writeData;
    logic [rvCorePkg::xlen-1:0] pcPlus4;

    rvCorePkg::aluOp_t      aluOp;
    rvCorePkg::immSel_t     immSel;
    rvCorePkg::memMode_t    memMode;
    rvCorePkg::resultSel_t  resultSel;
    rvCorePkg::pcSel_t      pcSel;
    rvCorePkg::branchCond_t branchCond;

    logic aluSrc;
    logic regWrite;
    logic memWrite;
    logic branch;
    logic jump;
    logic zero;
    logic lessThan;
    logic lessThanU;
    logic loadWe;

    // Loading only while the core is held in reset
    assign loadWe  = progWe & reset;
    assign pcPlus4 = pc + 32'd4;

    // ALU second operand
    assign srcB = aluSrc ? imm : readData2;

    // Register write-back source
    always_comb begin
        case (resultSel)
            rvCorePkg::resMem:     writeData = readData;
            rvCorePkg::resPcPlus4: writeData = pcPlus4;
            default:               writeData = aluResult;
        endcase
    end

    programCounter pcReg (
        .clk(clk), .reset(reset), .imm(imm), .aluResult(aluResult),
        .zero(zero), .lessThan(lessThan), .lessThanU(lessThanU),
        .branch(branch), .jump(jump), .pcSel(pcSel), .branchCond(branchCond),
        .pc(pc)
    );

    instrMemory instrMem (
        .clk(clk), .progWe(loadWe), .progAddr(progAddr), .progData(progData),
        .pc(pc), .instr(instr)
    );

    controlUnit ctrl (
        .instr(instr), .aluOp(aluOp), .aluSrc(aluSrc), .immSel(immSel),
        .regWrite(regWrite), .memWrite(memWrite), .memMode(memMode),
        .resultSel(resultSel), .pcSel(pcSel), .branch(branch), .jump(jump),
        .branchCond(branchCond), .reset(reset)
    );

    immExtend immExt (.instr(instr), .immSel(immSel), .imm(imm));

    regFile regs (
        .clk(clk), .rs1(instr[19:15]), .rs2(instr[24:20]), .rd(instr[11:7]),
        .regWrite(regWrite), .writeData(writeData),
        .readData1(readData1), .readData2(readData2),
        .a0(a0), .a1(a1), .a7(a7)
    );

    alu aluUnit (
        .srcA(readData1), .srcB(srcB), .aluOp(aluOp), .aluResult(aluResult),
        .zero(zero), .lessThan(lessThan), .lessThanU(lessThanU)
    );

    dataMemory dataMem (
        .clk(clk), .memWrite(memWrite), .memMode(memMode), .addr(aluResult),
        .writeData(readData2), .readData(readData)
    );

endmodule

//--- dataMemory.sv
// Little-endian 256-byte data store, only addr bits 7..0 are decoded.
// Misaligned half and word accesses are undefined.
`timescale 1ns/10ps
module dataMemory (
    input  logic                         clk,
    input  logic                         memWrite,
    input  rvCorePkg::memMode_t          memMode,
    input  logic [rvCorePkg::xlen-1:0]   addr,
    input  logic [rvCorePkg::xlen-1:0]   writeData,
    output logic [rvCorePkg::xlen-1:0]   readData
);

    localparam int addrBits = $clog2(rvCorePkg::dmemBytes);

    logic [7:0]                 mem [rvCorePkg::dmemBytes];
    logic [addrBits-1:0]        a;
    logic [rvCorePkg::xlen-1:0] word;

    assign a = addr[addrBits-1:0];

    always_ff @(posedge clk) begin
        if (memWrite) begin
            mem[a] <= writeData[7:0];
            if (memMode == rvCorePkg::memHalf || memMode == rvCorePkg::memWord) begin
                mem[a + 1'b1] <= writeData[15:8];
            end
            if (memMode == rvCorePkg::memWord) begin
                mem[a + 2'd2] <= writeData[23:16];
                mem[a + 2'd3] <= writeData[31:24];
            end
        end
    end

    // Four bytes from addr upward, then size and extension
    assign word = {mem[a + 2'd3], mem[a + 2'd2], mem[a + 1'b1], mem[a]};

    always_comb begin
        case (memMode)
            rvCorePkg::memByte:         readData = {{24{word[7]}}, word[7:0]};
            rvCorePkg::memHalf:         readData = {{16{word[15]}}, word[15:0]};
            rvCorePkg::memByteUnsigned: readData = {24'b0, word[7:0]};
            rvCorePkg::memHalfUnsigned: readData = {16'b0, word[15:0]};
            default:                    readData = word;
        endcase
    end

endmodule

//--- alu.sv
// Integer ALU. Flags always compare srcA with srcB, whatever aluOp is.
`timescale 1ns/10ps
module alu (
    input  logic [rvCorePkg::xlen-1:0]   srcA,
    input  logic [rvCorePkg::xlen-1:0]   srcB,
    input  rvCorePkg::aluOp_t            aluOp,
    output logic [rvCorePkg::xlen-1:0]   aluResult,
    output logic                         zero,
    output logic                         lessThan,
    output logic                         lessThanU
);

    logic [rvCorePkg::xlen-1:0] diff;
    logic [4:0]                 shamt;

    assign diff      = srcA - srcB;
    assign shamt     = srcB[4:0];
    assign zero      = (diff == '0);
    assign lessThan  = $signed(srcA) < $signed(srcB);
    assign lessThanU = srcA < srcB;

    always_comb begin
        case (aluOp)
            rvCorePkg::aluSub:   aluResult = diff;
            rvCorePkg::aluAnd:   aluResult = srcA & srcB;
            rvCorePkg::aluOr:    aluResult = srcA | srcB;
            rvCorePkg::aluXor:   aluResult = srcA ^ srcB;
            rvCorePkg::aluSlt:   aluResult = {31'b0, lessThan};
            rvCorePkg::aluSltu:  aluResult = {31'b0, lessThanU};
            rvCorePkg::aluSll:   aluResult = srcA << shamt;
            rvCorePkg::aluSrl:   aluResult = srcA >> shamt;
            rvCorePkg::aluSra:   aluResult = $signed(srcA) >>> shamt;
            // lui
            rvCorePkg::aluPassB: aluResult = srcB;
            default:             aluResult = srcA + srcB;
        endcase
    end

endmodule

//--- regFile.sv
// 32 x 32-bit register file, x0 reads as zero and ignores writes.
// Contents are not cleared by reset.
`timescale 1ns/10ps
module regFile (
    input  logic                         clk,
    input  logic [4:0]                   rs1,
    input  logic [4:0]                   rs2,
    input  logic [4:0]                   rd,
    input  logic                         regWrite,
    input  logic [rvCorePkg::xlen-1:0]   writeData,
    output logic [rvCorePkg::xlen-1:0]   readData1,
    output logic [rvCorePkg::xlen-1:0]   readData2,
    output logic [rvCorePkg::xlen-1:0]   a0,
    output logic [rvCorePkg::xlen-1:0]   a1,
    output logic [rvCorePkg::xlen-1:0]   a7
);

    logic [rvCorePkg::xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (regWrite && rd != 5'd0) begin
            regs[rd] <= writeData;
        end
    end

    assign readData1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign readData2 = (rs2 == 5'd0) ? '0 : regs[rs2];

    // Argument and syscall registers for observation
    assign a0 = regs[10];
    assign a1 = regs[11];
    assign a7 = regs[17];

endmodule

//--- immExtend.sv
// Immediate reassembly for the I, S, B, J and U formats.
`timescale 1ns/10ps
module immExtend (
    input  logic [rvCorePkg::xlen-1:0]   instr,
    input  rvCorePkg::immSel_t           immSel,
    output logic [rvCorePkg::xlen-1:0]   imm
);

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (immSel)
            rvCorePkg::immS: imm = {{20{sign}}, instr[31:25], instr[11:7]};
            // Branch and jump offsets are in half-words
            rvCorePkg::immB: imm = {{19{sign}}, instr[31], instr[7],
                                    instr[30:25], instr[11:8], 1'b0};
            rvCorePkg::immJ: imm = {{11{sign}}, instr[31], instr[19:12],
                                    instr[20], instr[30:21], 1'b0};
            rvCorePkg::immU: imm = {instr[31:12], 12'b0};
            default:         imm = {{20{sign}}, instr[31:20]};
        endcase
    end

endmodule

//--- controlUnit.sv
// Decodes opcode, funct3 and funct7 bit 5 into datapath controls.
// Unsupported opcodes fall through as a no-op that writes nothing.
`timescale 1ns/10ps
module controlUnit (
    input  logic [rvCorePkg::xlen-1:0]   instr,
    output rvCorePkg::aluOp_t            aluOp,
    output logic                         aluSrc,
    output rvCorePkg::immSel_t           immSel,
    output logic                         regWrite,
    output logic                         memWrite,
    output rvCorePkg::memMode_t          memMode,
    output rvCorePkg::resultSel_t        resultSel,
    output rvCorePkg::pcSel_t            pcSel,
    output logic                         branch,
    output logic                         jump,
    output rvCorePkg::branchCond_t       branchCond,
    input  logic                         reset
);

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic              funct7b5;
    logic              regWriteDec;
    logic              memWriteDec;
    rvCorePkg::aluOp_t arithOp;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

    // Passed through untouched, interpreted downstream
    assign memMode    = rvCorePkg::memMode_t'(funct3);
    assign branchCond = rvCorePkg::branchCond_t'(funct3);

    // No architectural writes while held in reset
    assign regWrite = regWriteDec & ~reset;
    assign memWrite = memWriteDec & ~reset;

    // Register and immediate arithmetic; sub only exists in register form
    always_comb begin
        case (funct3)
            3'b000:  arithOp = (opcode == rvCorePkg::opOp && funct7b5) ?
                               rvCorePkg::aluSub : rvCorePkg::aluAdd;
            3'b001:  arithOp = rvCorePkg::aluSll;
            3'b010:  arithOp = rvCorePkg::aluSlt;
            3'b011:  arithOp = rvCorePkg::aluSltu;
            3'b100:  arithOp = rvCorePkg::aluXor;
            3'b101:  arithOp = funct7b5 ? rvCorePkg::aluSra : rvCorePkg::aluSrl;
            3'b110:  arithOp = rvCorePkg::aluOr;
            default: arithOp = rvCorePkg::aluAnd;
        endcase
    end

    always_comb begin
        aluOp       = rvCorePkg::aluAdd;
        aluSrc      = 1'b0;
        immSel      = rvCorePkg::immI;
        regWriteDec = 1'b0;
        memWriteDec = 1'b0;
        resultSel   = rvCorePkg::resAlu;
        pcSel       = rvCorePkg::pcSelPlus4;
        branch      = 1'b0;
        jump        = 1'b0;
        case (opcode)
            rvCorePkg::opOp: begin
                aluOp       = arithOp;
                regWriteDec = 1'b1;
            end
            rvCorePkg::opOpImm: begin
                aluOp       = arithOp;
                aluSrc      = 1'b1;
                regWriteDec = 1'b1;
            end
            rvCorePkg::opLoad: begin
                aluSrc      = 1'b1;
                regWriteDec = 1'b1;
                resultSel   = rvCorePkg::resMem;
            end
            rvCorePkg::opStore: begin
                aluSrc      = 1'b1;
                immSel      = rvCorePkg::immS;
                memWriteDec = 1'b1;
            end
            rvCorePkg::opBranch: begin
                // Flags from rs1 - rs2
                aluOp  = rvCorePkg::aluSub;
                immSel = rvCorePkg::immB;
                pcSel  = rvCorePkg::pcSelBranch;
                branch = 1'b1;
            end
            rvCorePkg::opJal: begin
                immSel      = rvCorePkg::immJ;
                regWriteDec = 1'b1;
                resultSel   = rvCorePkg::resPcPlus4;
                pcSel       = rvCorePkg::pcSelBranch;
                jump        = 1'b1;
            end
            rvCorePkg::opJalr: begin
                aluSrc      = 1'b1;
                regWriteDec = 1'b1;
                resultSel   = rvCorePkg::resPcPlus4;
                pcSel       = rvCorePkg::pcSelAlu;
                jump        = 1'b1;
            end
            rvCorePkg::opLui: begin
                aluOp       = rvCorePkg::aluPassB;
                aluSrc      = 1'b1;
                immSel      = rvCorePkg::immU;
                regWriteDec = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

//--- instrMemory.sv
// Word-addressed instruction store, fetch is combinational.
// PC bits above the array index are ignored, so fetches wrap.
`timescale 1ns/10ps
module instrMemory (
    input  logic                         clk,
    input  logic                         progWe,
    input  logic [7:0]                   progAddr,
    input  logic [31:0]                  progData,
    input  logic [rvCorePkg::xlen-1:0]   pc,
    output logic [rvCorePkg::xlen-1:0]   instr
);

    localparam int idxBits = $clog2(rvCorePkg::imemWords);

    logic [rvCorePkg::xlen-1:0] mem [rvCorePkg::imemWords];

    // Program load port
    always_ff @(posedge clk) begin
        if (progWe) begin
            mem[progAddr] <= progData;
        end
    end

    assign instr = mem[pc[idxBits+1:2]];

endmodule

//--- programCounter.sv
// PC register and next-address logic; resets to address 0.
`timescale 1ns/10ps
module programCounter (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [rvCorePkg::xlen-1:0]   imm,
    input  logic [rvCorePkg::xlen-1:0]   aluResult,
    input  logic                         zero,
    input  logic                         lessThan,
    input  logic                         lessThanU,
    input  logic                         branch,
    input  logic                         jump,
    input  rvCorePkg::pcSel_t            pcSel,
    input  rvCorePkg::branchCond_t       branchCond,
    output logic [rvCorePkg::xlen-1:0]   pc
);

    logic [rvCorePkg::xlen-1:0] pcPlus4;
    logic [rvCorePkg::xlen-1:0] pcPlusImm;
    logic [rvCorePkg::xlen-1:0] nextPc;
    logic                       taken;

    assign pcPlus4   = pc + 32'd4;
    assign pcPlusImm = pc + imm;

    // Branch outcome from the ALU compare flags
    always_comb begin
        case (branchCond)
            rvCorePkg::brEq:  taken = zero;
            rvCorePkg::brNe:  taken = ~zero;
            rvCorePkg::brLt:  taken = lessThan;
            rvCorePkg::brGe:  taken = ~lessThan;
            rvCorePkg::brLtu: taken = lessThanU;
            rvCorePkg::brGeu: taken = ~lessThanU;
            default:          taken = 1'b0;
        endcase
    end

    always_comb begin
        case (pcSel)
            // jalr target has bit 0 cleared
            rvCorePkg::pcSelAlu:    nextPc = {aluResult[rvCorePkg::xlen-1:1], 1'b0};
            rvCorePkg::pcSelBranch: nextPc = (jump || (branch && taken)) ? pcPlusImm : pcPlus4;
            default:                nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

//--- rvCorePkg.sv
// Shared widths, depths and control encodings for the single-cycle RV32I core.
// memMode_t and branchCond_t values equal the instruction funct3 field.
package rvCorePkg;

    // Word width and memory depths
    localparam int xlen      = 32;
    localparam int imemWords = 256;
    localparam int dmemBytes = 256;

    // Major opcodes of the supported subset
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opOp     = 7'b0110011;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSltu,
        aluSll, aluSrl, aluSra, aluPassB
    } aluOp_t;

    typedef enum logic [2:0] {
        immI, immS, immB, immJ, immU
    } immSel_t;

    // Register write source
    typedef enum logic [1:0] {
        resAlu, resMem, resPcPlus4
    } resultSel_t;

    typedef enum logic [1:0] {
        pcSelPlus4, pcSelBranch, pcSelAlu
    } pcSel_t;

    typedef enum logic [2:0] {
        memByte         = 3'b000,
        memHalf         = 3'b001,
        memWord         = 3'b010,
        memByteUnsigned = 3'b100,
        memHalfUnsigned = 3'b101
    } memMode_t;

    typedef enum logic [2:0] {
        brEq  = 3'b000,
        brNe  = 3'b001,
        brLt  = 3'b100,
        brGe  = 3'b101,
        brLtu = 3'b110,
        brGeu = 3'b111
    } branchCond_t;

endpackage
